// File: all.f
+incdir+include
logic/arb_pkg.sv
logic/arb_node_2req.sv
logic/arb_tree.sv
logic/grant_mux.sv
logic/arb_switch_top.sv
verification/arb_switch_asserts.sv
verification/arb_checker.sv
verification/tb_arb_switch.sv

// File: Bender.yml
package:
  name: arb_switch

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/arb_pkg.sv
      - logic/arb_node_2req.sv
      - logic/arb_tree.sv
      - logic/grant_mux.sv
      - logic/arb_switch_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/arb_switch_asserts.sv
      - verification/arb_checker.sv
      - verification/tb_arb_switch.sv

// File: verification/tb_arb_switch.sv
`timescale 1ns/10ps

`include "arb_macros.svh"

module tb_arb_switch;

    import arb_pkg::*;

    localparam int N          = `ARB_NUM_PORTS;
    localparam int RESET_CYC  = 16;
    localparam int MARGIN     = 200; // extra cycles for the final drain
    localparam int NROWS      = 12;
    localparam int READY_ALL  = 0;   // consumer always ready
    localparam int READY_NONE = 1;   // consumer stalls
    localparam int READY_RAND = 2;   // ready with given percent

    logic          clk;
    logic          rst_n;
    logic          en;
    port_mask_t    req;
    data_t [N-1:0] req_data;
    port_mask_t    ack;
    logic          out_valid;
    data_t         out_data;
    port_id_t      out_src;
    logic          ready;

    port_mask_t    ack_seen;   // o_ack as it stood at the last edge
    logic [7:0]    seq [N];    // offer count per requester
    logic [127:0]  cur_name;   // row under test
    int            errors;
    int            transfers;
    int            assert_fails; // failed bound assertions
    int            cycle_count = 0;
    int            cycle_limit = 0;
    int            row_cnt = 0;

    // stimulus table
    logic [127:0]  row_name   [NROWS];
    port_mask_t    row_mask   [NROWS];
    logic          row_en     [NROWS];
    int            row_ready  [NROWS];
    int            row_pct    [NROWS];
    int            row_cycles [NROWS];

    arb_switch_top u_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_en    (en),
        .i_req   (req),
        .i_data  (req_data),
        .o_ack   (ack),
        .o_valid (out_valid),
        .o_data  (out_data),
        .o_src   (out_src),
        .i_ready (ready)
    );

    arb_checker u_checker (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_en        (en),
        .i_req       (req),
        .i_data      (req_data),
        .i_ready     (ready),
        .i_ack       (ack),
        .i_valid     (out_valid),
        .i_out_data  (out_data),
        .i_src       (out_src),
        .i_test_name (cur_name),
        .o_errors    (errors),
        .o_transfers (transfers)
    );

    bind arb_switch_top arb_switch_asserts u_asserts (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_en    (i_en),
        .i_req   (i_req),
        .o_ack   (o_ack),
        .o_valid (o_valid),
        .o_data  (o_data),
        .o_src   (o_src),
        .i_ready (i_ready)
    );

    assign assert_fails = u_dut.u_asserts.fail_count;

    always #5 clk = ~clk;

    always @(negedge clk)
    begin
        ack_seen = ack; // settled value for the coming edge
    end

    // run limit
    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit)
        begin
            $display("timeout after %0d cycles, traffic did not drain", cycle_count);
            $display("errors %0d, assertion failures %0d, transfers checked %0d",
                     errors, assert_fails, transfers);
            $display("test failed");
            $finish;
        end
    end

    task automatic add_row(input logic [127:0] name, input port_mask_t mask, input logic row_on,
                           input int ready_mode, input int pct, input int cycles);
        row_name[row_cnt]   = name;
        row_mask[row_cnt]   = mask;
        row_en[row_cnt]     = row_on;
        row_ready[row_cnt]  = ready_mode;
        row_pct[row_cnt]    = pct;
        row_cycles[row_cnt] = cycles;
        row_cnt++;
    endtask

    // drives one cycle of requester stubs and consumer 1 ns after the edge
    task automatic drive_cycle(input logic [127:0] name, input port_mask_t mask,
                               input logic row_on, input int ready_mode, input int pct);
        @(posedge clk);
        #1;
        cur_name = name;
        for (int p = 0; p < N; p++)
        begin
            if (ack_seen[p])
            begin
                seq[p] = seq[p] + 8'd1; // offer taken so move to the next one
            end
            req[p]      = mask[p] | (req[p] & ~ack_seen[p]); // pending stays up
            req_data[p] = {8'(p), seq[p]};
        end
        en = row_on;
        case (ready_mode)
            READY_ALL:  ready = 1'b1;
            READY_NONE: ready = 1'b0;
            default:    ready = (($urandom % 100) < pct);
        endcase
    endtask

    initial
    begin
        int total;
        void'($urandom(32'h436f_47bf));
        clk      = 1'b0;
        rst_n    = 1'b0;
        en       = 1'b0;
        req      = '0;
        req_data = '0;
        ready    = 1'b0;
        ack_seen = '0;
        cur_name = "reset";
        for (int p = 0; p < N; p++)
        begin
            seq[p] = 8'd0;
        end
        add_row("reset_all", 4'b1111, 1'b1, READY_ALL,  0,  24);
        add_row("single_p2", 4'b0100, 1'b1, READY_ALL,  0,  12);
        add_row("pair_01",   4'b0011, 1'b1, READY_ALL,  0,  12);
        add_row("pair_02",   4'b0101, 1'b1, READY_ALL,  0,  12);
        add_row("bp_random", 4'b1111, 1'b1, READY_RAND, 50, 60);
        add_row("bp_stall",  4'b1111, 1'b1, READY_NONE, 0,  10);
        add_row("en_pause",  4'b1111, 1'b0, READY_ALL,  0,  10); // held item drains
        add_row("en_resume", 4'b1111, 1'b1, READY_ALL,  0,  16);
        add_row("mask_1010", 4'b1010, 1'b1, READY_RAND, 70, 30);
        add_row("mask_0111", 4'b0111, 1'b1, READY_ALL,  0,  20);
        add_row("mask_1001", 4'b1001, 1'b1, READY_RAND, 30, 30);
        add_row("all_final", 4'b1111, 1'b1, READY_ALL,  0,  20);
        total = 0;
        for (int r = 0; r < row_cnt; r++)
        begin
            total += row_cycles[r];
        end
        cycle_limit = total + RESET_CYC + MARGIN;
        repeat (RESET_CYC) @(posedge clk);
        #1 rst_n = 1'b1;
        for (int r = 0; r < row_cnt; r++)
        begin
            repeat (row_cycles[r])
            begin
                drive_cycle(row_name[r], row_mask[r], row_en[r], row_ready[r], row_pct[r]);
            end
        end
        // let pending requests and the held item go out
        while (req != '0 || out_valid)
        begin
            drive_cycle("drain", '0, 1'b1, READY_ALL, 0);
        end
        repeat (2) @(posedge clk);
        $display("errors %0d, assertion failures %0d, transfers checked %0d",
                 errors, assert_fails, transfers);
        if (errors == 0 && assert_fails == 0 && transfers > 0)
        begin
            $display("test passed");
        end
        else
        begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: verification/arb_checker.sv
`timescale 1ns/10ps

`include "arb_macros.svh"

// reference model of the switch
// mirrors the node tree by the last-served rule, queues every predicted accept
// and compares each output transfer against the queue head
module arb_checker (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                i_en,
    input  arb_pkg::port_mask_t                 i_req,
    input  arb_pkg::data_t [`ARB_NUM_PORTS-1:0] i_data,
    input  logic                                i_ready,
    input  arb_pkg::port_mask_t                 i_ack,       // dut o_ack
    input  logic                                i_valid,     // dut o_valid
    input  arb_pkg::data_t                      i_out_data,  // dut o_data
    input  arb_pkg::port_id_t                   i_src,       // dut o_src
    input  logic [127:0]                        i_test_name, // 16 chars
    output int                                  o_errors,
    output int                                  o_transfers
);

    import arb_pkg::*;

    localparam int N = `ARB_NUM_PORTS;

    logic     last_b [N-1]; // 1 means the node served its b side last
    port_id_t q_src [$];    // accepted but not yet taken by the consumer
    data_t    q_data [$];
    int       errors = 0;
    int       transfers = 0;
    int       since_reset = 0;          // transfers after reset release
    int       order [4] = '{0, 2, 1, 3}; // service order of all four on a fresh tree

    assign o_errors    = errors;
    assign o_transfers = transfers;

    // any request among ports lo .. lo+cnt-1
    function automatic logic any_req(input port_mask_t mask, input int lo, input int cnt);
        logic hit;
        hit = 1'b0;
        for (int i = lo; i < lo + cnt; i++)
        begin
            hit = hit | mask[i];
        end
        return hit;
    endfunction

    // walk from the root where the a side holds the lower half of the ports
    function automatic int pick_port(input port_mask_t mask);
        int   node;
        int   lo;
        int   span;
        logic a_req;
        logic b_req;
        node = 0;
        lo   = 0;
        span = N;
        while (span > 1)
        begin
            span  = span / 2;
            a_req = any_req(mask, lo, span);
            b_req = any_req(mask, lo + span, span);
            if (b_req && (!a_req || !last_b[node])) // b alone, or a had the last turn
            begin
                lo   = lo + span;
                node = 2 * node + 2;
            end
            else
            begin
                node = 2 * node + 1;
            end
        end
        return lo;
    endfunction

    // nodes on the path to the served port remember their side
    task automatic record_service(input int id);
        int   node;
        int   lo;
        int   span;
        logic take_b;
        node = 0;
        lo   = 0;
        span = N;
        while (span > 1)
        begin
            span   = span / 2;
            take_b = (id >= lo + span);
            last_b[node] = take_b;
            lo   = take_b ? lo + span : lo;
            node = take_b ? 2 * node + 2 : 2 * node + 1;
        end
    endtask

    task automatic report_value(input string what, input logic [31:0] expected,
                                input logic [31:0] actual);
        errors++;
        $display("Fail %0s %0s expected %0h actual %0h", i_test_name, what, expected, actual);
    endtask

    // inputs and outputs have settled by the negedge before each edge
    always @(negedge clk)
    begin : b_model
        port_mask_t exp_ack;
        int         exp_id;
        logic       room;
        logic       accept;
        if (!rst_n)
        begin
            for (int k = 0; k < N - 1; k++)
            begin
                last_b[k] = 1'b1; // b counts as served
            end
            q_src.delete();
            q_data.delete();
            since_reset = 0;
            if (i_valid !== 1'b0)
            begin
                report_value("reset valid", 1'b0, i_valid);
            end
        end
        else
        begin
            room = (q_src.size() == 0) || i_ready; // empty, or drained at this edge
            if (i_valid !== (q_src.size() != 0))
            begin
                report_value("valid", q_src.size() != 0, i_valid);
            end
            if (i_valid && i_ready)
            begin
                if (q_src.size() == 0)
                begin
                    errors++;
                    $display("output transfer with no accepted item in %0s", i_test_name);
                end
                else
                begin
                    if (i_src !== q_src[0])
                    begin
                        report_value("src", q_src[0], i_src);
                    end
                    if (i_out_data !== q_data[0])
                    begin
                        report_value("data", q_data[0], i_out_data);
                    end
                    if (since_reset < 8 && i_src !== order[since_reset % 4])
                    begin
                        report_value("reset order", order[since_reset % 4], i_src);
                    end
                    void'(q_src.pop_front());
                    void'(q_data.pop_front());
                    since_reset++;
                    transfers++;
                end
            end
            accept  = i_en && (i_req != '0) && room;
            exp_id  = pick_port(i_req);
            exp_ack = accept ? port_mask_t'(1 << exp_id) : '0;
            if (i_ack !== exp_ack)
            begin
                report_value("ack", exp_ack, i_ack);
            end
            if (accept)
            begin
                q_src.push_back(port_id_t'(exp_id));
                q_data.push_back(i_data[exp_id]); // what the requester offers now
                record_service(exp_id);
            end
        end
    end

endmodule

// File: verification/arb_switch_asserts.sv
`timescale 1ns/10ps

// handshake and grant rules of the switch
// bound onto arb_switch_top with port names that follow the dut
module arb_switch_asserts (
    input logic                clk,
    input logic                rst_n,
    input logic                i_en,
    input arb_pkg::port_mask_t i_req,
    input arb_pkg::port_mask_t o_ack,
    input logic                o_valid,
    input arb_pkg::data_t      o_data,
    input arb_pkg::port_id_t   o_src,
    input logic                i_ready
);

    int fail_count = 0; // assertion failures so far

    // one requester served per cycle at most
    a_ack_onehot : assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(o_ack))
    else
    begin
        fail_count++;
        $error("o_ack has more than one bit set: %b", o_ack);
    end

    // stalled output keeps its item untouched
    a_hold_stable : assert property (@(posedge clk) disable iff (!rst_n)
        (o_valid && !i_ready) |=> (o_valid && $stable(o_data) && $stable(o_src)))
    else
    begin
        fail_count++;
        $error("output item changed while stalled");
    end

    // disabled switch hands out nothing
    a_no_ack_disabled : assert property (@(posedge clk) disable iff (!rst_n)
        !i_en |-> (o_ack == '0))
    else
    begin
        fail_count++;
        $error("o_ack %b given while i_en is low", o_ack);
    end

    // ack only toward a live request
    a_ack_has_req : assert property (@(posedge clk) disable iff (!rst_n)
        (o_ack & ~i_req) == '0)
    else
    begin
        fail_count++;
        $error("o_ack %b without request, i_req %b", o_ack, i_req);
    end

endmodule

// File: logic/arb_switch_top.sv
`timescale 1ns/10ps

`include "arb_macros.svh"

// four-to-one request switch
// arbiter tree picks a winner, grant_mux holds it for the consumer
module arb_switch_top (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                i_en,    // pauses new grants
    input  arb_pkg::port_mask_t                 i_req,   // requester wants out
    input  arb_pkg::data_t [`ARB_NUM_PORTS-1:0] i_data,  // payload per requester
    output arb_pkg::port_mask_t                 o_ack,   // request taken
    output logic                                o_valid,
    output arb_pkg::data_t                      o_data,
    output arb_pkg::port_id_t                   o_src,   // source port of o_data
    input  logic                                i_ready
);

    import arb_pkg::*;

    port_mask_t tree_grant; // one-hot winner
    port_id_t   tree_id;    // same winner, encoded
    logic       tree_any;   // winner exists and enabled
    logic       update;     // accept strobe back into the nodes

    arb_tree u_tree (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_en     (i_en),
        .i_req    (i_req),
        .i_update (update),
        .o_grant  (tree_grant),
        .o_id     (tree_id),
        .o_any    (tree_any)
    );

    grant_mux u_mux (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_any    (tree_any),
        .i_grant  (tree_grant),
        .i_id     (tree_id),
        .i_data   (i_data),
        .i_ready  (i_ready),
        .o_update (update),
        .o_ack    (o_ack),
        .o_valid  (o_valid),
        .o_data   (o_data),
        .o_src    (o_src)
    );

endmodule

// File: logic/grant_mux.sv
`timescale 1ns/10ps

`include "arb_macros.svh"

// output stage of the switch
// picks the winner's payload and parks it in a single holding register
// valid/ready toward the consumer, one-hot ack back to the requesters
module grant_mux (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                i_any,   // tree has a winner
    input  arb_pkg::port_mask_t                 i_grant, // winner, one-hot
    input  arb_pkg::port_id_t                   i_id,    // winner, encoded
    input  arb_pkg::data_t [`ARB_NUM_PORTS-1:0] i_data,  // payload per port
    input  logic                                i_ready, // consumer takes o_data
    output logic                                o_update, // tell nodes to record
    output arb_pkg::port_mask_t                 o_ack,   // request taken
    output logic                                o_valid, // holding reg full
    output arb_pkg::data_t                      o_data,
    output arb_pkg::port_id_t                   o_src    // port o_data came from
);

    import arb_pkg::*;

    logic  accept;   // winner moves into the holding register this cycle
    logic  room;     // register empty now or emptied at this edge
    data_t sel_data; // winner's payload

    // free slot, or the current item leaves at this very edge
    assign room = ~o_valid | i_ready;

    // no i_en here, the tree drops i_any while disabled
    assign accept = i_any & room;

    // nodes on the winning path only move on a real accept
    assign o_update = accept;

    // ack goes back in the same cycle as the request
    assign o_ack = accept ? i_grant : '0;

    // payload select by winner number
    assign sel_data = i_data[i_id];

    // holding register occupancy
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            o_valid <= 1'b0;
        end
        else if (accept)
        begin
            o_valid <= 1'b1; // refill, even if draining at the same edge
        end
        else if (i_ready)
        begin
            o_valid <= 1'b0; // drained, nothing new
        end
    end

    // payload and source, only loaded on accept
    // held otherwise, so stable under back-pressure
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            o_data <= sel_data;
            o_src  <= i_id;
        end
    end

endmodule

// File: logic/arb_tree.sv
`timescale 1ns/10ps

`include "arb_macros.svh"

// binary tree of two-request nodes
// heap numbering, node k has children 2k+1 (a side) and 2k+2 (b side)
// slots N-1 .. 2N-2 are the raw request bits, so leaves index like nodes
module arb_tree (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                i_en,     // no grant while low
    input  arb_pkg::port_mask_t i_req,    // one bit per requester
    input  logic                i_update, // accept strobe from output stage
    output arb_pkg::port_mask_t o_grant,  // one-hot, or zero when idle
    output arb_pkg::port_id_t   o_id,     // number of the winner
    output logic                o_any     // some grant this cycle
);

    import arb_pkg::*;

    localparam int N     = `ARB_NUM_PORTS;
    localparam int ID_W  = `ARB_ID_W;
    localparam int NODES = N - 1; // full binary tree

    wire [2*N-2:0] vld;      // node valids followed by raw requests
    wire [NODES-1:0] gnt_b;  // per node choice
    wire [NODES-1:0] on_path; // node lies on the route to the winner
    wire [NODES-1:0] node_upd;

    port_id_t path_id; // root decision in the msb

    // raw requests sit below the last level of nodes
    for (genvar p = 0; p < N; p++)
    begin : g_req_in
        assign vld[NODES+p] = i_req[p];
    end

    // root is always on the path
    assign on_path[0] = 1'b1;

    for (genvar k = 0; k < NODES; k++)
    begin : g_node
        // only the node on the winning route records the service
        assign node_upd[k] = i_update & on_path[k];

        arb_node_2req u_node (
            .clk       (clk),
            .rst_n     (rst_n),
            .i_en      (i_en),
            .i_req_a   (vld[2*k+1]),
            .i_req_b   (vld[2*k+2]),
            .i_update  (node_upd[k]),
            .o_grant_b (gnt_b[k]),
            .o_valid   (vld[k])
        );

        // follow the parent's choice downwards
        if (k > 0)
        begin : g_path
            localparam int PARENT = (k - 1) / 2;
            if (k % 2 == 1)
            begin : g_side_a
                assign on_path[k] = on_path[PARENT] & ~gnt_b[PARENT];
            end
            else
            begin : g_side_b
                assign on_path[k] = on_path[PARENT] & gnt_b[PARENT];
            end
        end
    end

    // one id bit per level
    // the single on-path node of that level gives its grant_b
    for (genvar lvl = 0; lvl < ID_W; lvl++)
    begin : g_lvl
        localparam int FIRST = (1 << lvl) - 1; // leftmost node of level
        localparam int CNT   = 1 << lvl;
        wire [CNT-1:0] hit;
        for (genvar n = 0; n < CNT; n++)
        begin : g_hit
            assign hit[n] = on_path[FIRST+n] & gnt_b[FIRST+n];
        end
        assign path_id[ID_W-1-lvl] = |hit;
    end

    // root valid covers every request, enable kills it here
    assign o_any = i_en & vld[0];
    assign o_id  = path_id;

    // id back to a one-hot mask
    always_comb
    begin
        o_grant = '0;
        if (o_any)
        begin
            o_grant[path_id] = 1'b1;
        end
    end

endmodule

// File: logic/arb_node_2req.sv
`timescale 1ns/10ps

// one decision point of the tree
// a is always the lower-numbered side
module arb_node_2req (
    input  logic clk,
    input  logic rst_n,
    input  logic i_en,      // low freezes the last-served bit
    input  logic i_req_a,   // request from lower side
    input  logic i_req_b,   // request from upper side
    input  logic i_update,  // winner behind this node got accepted
    output logic o_grant_b, // 0 picks a, 1 picks b
    output logic o_valid    // something below wants service
);

    logic last_b; // side served last, 1 means b

    // either side requesting makes this node a candidate upstream
    assign o_valid = i_req_a | i_req_b;

    // b alone wins
    // a and b together, b wins only if a went last
    // a alone or nobody gives 0
    assign o_grant_b = i_req_b & (~i_req_a | ~last_b);

    // last-served bit
    // only moves when the grant is really taken
    // so a stalled output leaves the preference alone
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            last_b <= 1'b1; // b counts as served, a takes the first contest
        end
        else if (i_en && i_update && o_valid)
        begin
            last_b <= o_grant_b; // remember who got through
        end
    end

endmodule

// File: logic/arb_pkg.sv
`include "arb_macros.svh"

package arb_pkg;

    // one bit per requester, bit i is port i
    typedef logic [`ARB_NUM_PORTS-1:0] port_mask_t;

    typedef logic [`ARB_ID_W-1:0] port_id_t; // requester number

    typedef logic [`ARB_DATA_W-1:0] data_t; // payload of one request

endpackage

// File: include/arb_macros.svh
`ifndef ARB_MACROS_SVH
`define ARB_MACROS_SVH

// requester count, any power of two from 2 up
`define ARB_NUM_PORTS 4

// payload width per requester
`define ARB_DATA_W 16

// bits needed to name one requester
`define ARB_ID_W $clog2(`ARB_NUM_PORTS)

`endif
